// ==== Bender.yml ====
package:
  name: rob_subsystem

sources:
  - verilog/phys_reg_pkg.sv
  - verilog/rob_pkg.sv
  - verilog/tag_cam.sv
  - verilog/rob.sv
  - verilog/arch_map.sv
  - verilog/rob_subsystem.sv
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/rob_subsystem_tb.sv

// ==== rob_subsystem.f ====
verilog/phys_reg_pkg.sv
verilog/rob_pkg.sv
verilog/tag_cam.sv
verilog/rob.sv
verilog/arch_map.sv
verilog/rob_subsystem.sv
tb/clock_gen.sv
tb/rob_subsystem_tb.sv

// ==== tb/clock_gen.sv ====
module clock_gen #(
	parameter int period = 100,
	parameter int reset_cycles = 10
) (
	output logic clock,
	output logic rst
);

	initial begin
		clock = 1'b0;
		rst = 1'b1;
		// Released on a rising edge
		repeat (reset_cycles) @(posedge clock);
		rst <= 1'b0;
	end

	always #(period / 2) clock = ~clock;

endmodule

// ==== tb/rob_subsystem_tb.sv ====
module rob_subsystem_tb import phys_reg_pkg::*, rob_pkg::*; ();
	localparam int rob_size = 8;
	localparam int ss_size = 2;
	localparam int timeout_cycles = 1000;

	logic clock;
	logic rst;
	logic flush;
	dispatch_pkt_t [ss_size-1:0] dispatch;
	cdb_pkt_t [ss_size-1:0] cdb;
	arch_idx_t arch_rd_idx;
	logic [$clog2(rob_size):0] free_rows;
	retire_pkt_t [ss_size-1:0] retire;
	phys_tag_t arch_rd_tag;
	logic halted;

	integer seed;
	int checks;
	int errors;
	int tag_ctr;
	int npc_ctr;
	int last_lanes;
	bit timed_out;
	bit model_halted;
	bit expect_empty;
	logic [$clog2(rob_size):0] seen_free;
	arch_idx_t last_dst;
	// Dispatched packets in program order, not yet retired
	dispatch_pkt_t order_q[$];
	// Tags dispatched but not yet broadcast
	phys_tag_t pending[$];
	phys_tag_t model_map[num_arch_reg];
	phys_tag_t spec_map[num_arch_reg];
	bit bcast[num_phys_reg];

	clock_gen clock_gen_i (.clock(clock), .rst(rst));
	rob_subsystem #(.rob_size(rob_size), .ss_size(ss_size)) rob_subsystem_i (.*);

	task automatic check_value(input string name, input logic [63:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	// Renamed against the speculative map, tags from the upper half
	function automatic dispatch_pkt_t make_pkt(input bit halt, input bit no_dst);
		dispatch_pkt_t p;
		p = '0;
		p.valid = 1'b1;
		p.halt = halt;
		p.has_dst = !no_dst && (($random(seed) & 3) != 0);
		p.arch_dst = arch_idx_t'($random(seed));
		p.npc = 32'(npc_ctr * 4);
		npc_ctr++;
		if (p.has_dst) begin
			p.t_new = phys_tag_t'(num_arch_reg + tag_ctr % (num_phys_reg - num_arch_reg));
			p.t_old = spec_map[p.arch_dst];
			spec_map[p.arch_dst] = p.t_new;
			bcast[p.t_new] = 1'b0;
			tag_ctr++;
		end
		return p;
	endfunction

	// Reference model: the oldest outstanding packet retires next
	function automatic dispatch_pkt_t next_retire();
		dispatch_pkt_t p;
		p = '0;
		if (order_q.size() > 0) begin
			p = order_q.pop_front();
		end
		if (p.has_dst) begin
			model_map[p.arch_dst] = p.t_new;
		end
		return p;
	endfunction

	task automatic step(input bit allow, input bit halt_now);
		dispatch_pkt_t [ss_size-1:0] d;
		cdb_pkt_t [ss_size-1:0] c;
		int lanes;
		int pick;
		d = '0;
		c = '0;
		// Random completion order among outstanding tags
		for (int l = 0; l < ss_size; l++) begin
			if (pending.size() > 0 && $random(seed) % 2 != 0) begin
				pick = $unsigned($random(seed)) % pending.size();
				c[l].valid = 1'b1;
				c[l].tag = pending[pick];
				bcast[pending[pick]] = 1'b1;
				pending.delete(pick);
			end
		end
		lanes = halt_now ? ss_size : (allow ? int'($unsigned($random(seed)) % (ss_size + 1)) : 0);
		// Lanes driven last cycle still take rows at the coming edge
		if (lanes > int'(seen_free) - last_lanes) begin
			lanes = int'(seen_free) - last_lanes;
		end
		for (int i = 0; i < lanes; i++) begin
			d[i] = make_pkt(halt_now && i == 0, halt_now);
			order_q.push_back(d[i]);
			if (d[i].has_dst) begin
				pending.push_back(d[i].t_new);
			end
		end
		last_lanes = lanes;
		dispatch <= d;
		cdb <= c;
		arch_rd_idx <= last_dst;
	endtask

	task automatic compare_cycle();
		dispatch_pkt_t want;
		logic [ss_size-1:0] vld;
		bit cut;
		cut = 1'b0;
		for (int i = 0; i < ss_size; i++) begin
			vld[i] = retire[i].valid;
		end
		check_value("retire_valid_packed", (vld & (vld + 1'b1)) == '0, 1);
		if (expect_empty) begin
			check_value("retire_valid", vld, 0);
		end
		for (int i = 0; i < ss_size; i++) begin
			if (vld[i]) begin
				want = next_retire();
				check_value("retire_after_halt", cut, 0);
				check_value($sformatf("retire[%0d]", i), retire[i], want);
				if (want.has_dst) begin
					check_value("retire_tag_broadcast", bcast[want.t_new], 1);
					last_dst = want.arch_dst;
				end
				cut = cut | want.halt;
			end
		end
		// Lanes driven this cycle are not in the buffer yet
		check_value("free_rows", free_rows, rob_size - order_q.size() + last_lanes);
		model_halted = model_halted | cut;
		check_value("halted", halted, model_halted);
		check_value("arch_rd_tag", arch_rd_tag, model_map[arch_rd_idx]);
		expect_empty = flush;
		seen_free = free_rows;
	endtask

	// Outputs sampled on the falling edge
	always @(negedge clock) begin
		if (!rst) begin
			compare_cycle();
		end
	end

	task automatic drain();
		int cnt;
		cnt = 0;
		while (order_q.size() > 0 && !timed_out) begin
			@(posedge clock);
			step(1'b0, 1'b0);
			cnt++;
			if (cnt > timeout_cycles) begin
				$display("timeout: %0d dispatched packets never retired", order_q.size());
				timed_out = 1'b1;
			end
		end
	endtask

	initial begin
		int cnt;
		seed = 32'h2d5f_f0de;
		expect_empty = 1'b1;
		seen_free = '0;
		last_dst = '0;
		flush = 1'b0;
		dispatch = '0;
		cdb = '0;
		arch_rd_idx = '0;
		for (int r = 0; r < num_arch_reg; r++) begin
			model_map[r] = phys_tag_t'(r);
		end
		spec_map = model_map;
		cnt = 0;
		while (rst !== 1'b0 && !timed_out) begin
			@(posedge clock);
			cnt++;
			if (cnt > timeout_cycles) begin
				$display("timeout: reset was never released");
				timed_out = 1'b1;
			end
		end
		if (!timed_out) begin
			// Identity map on every index
			for (int r = 0; r < num_arch_reg; r++) begin
				@(posedge clock);
				arch_rd_idx <= arch_idx_t'(r);
			end
			repeat (200) begin
				@(posedge clock);
				step(1'b1, 1'b0);
			end
			// Flush with rows in flight
			@(posedge clock);
			flush <= 1'b1;
			dispatch <= '0;
			cdb <= '0;
			last_lanes = 0;
			@(posedge clock);
			flush <= 1'b0;
			order_q.delete();
			pending.delete();
			spec_map = model_map;
			repeat (200) begin
				@(posedge clock);
				step(1'b1, 1'b0);
			end
			drain();
			// Halt in lane 0 with a younger done entry behind it
			@(posedge clock);
			step(1'b1, 1'b1);
			drain();
			@(posedge clock);
			check_value("halted_final", halted, 1);
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== verilog/arch_map.sv ====
module arch_map import phys_reg_pkg::*, rob_pkg::*; #(
	parameter int ss_size = 2
) (
	input logic clock,
	input logic rst,
	input retire_pkt_t [ss_size-1:0] commit,
	input arch_idx_t arch_rd_idx,
	output phys_tag_t arch_rd_tag,
	output retire_pkt_t [ss_size-1:0] retire,
	output logic halted
);

	phys_tag_t [num_arch_reg-1:0] map_q;
	phys_tag_t [num_arch_reg-1:0] map_next;
	logic t_old_err;
	logic halt_seen;

	assign arch_rd_tag = map_q[arch_rd_idx];

	// Lane order matters, a later lane overwrites an earlier one
	always_comb begin
		map_next = map_q;
		t_old_err = 1'b0;
		halt_seen = 1'b0;
		for (int i = 0; i < ss_size; i++) begin
			if (commit[i].valid && commit[i].has_dst) begin
				if (map_next[commit[i].arch_dst] != commit[i].t_old) begin
					t_old_err = 1'b1;
				end
				map_next[commit[i].arch_dst] = commit[i].t_new;
			end
			if (commit[i].valid && commit[i].halt) begin
				halt_seen = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			// Identity map out of reset
			for (int r = 0; r < num_arch_reg; r++) begin
				map_q[r] <= phys_tag_t'(r);
			end
			for (int i = 0; i < ss_size; i++) begin
				retire[i].valid <= 1'b0;
			end
			halted <= 1'b0;
		end else begin
			map_q <= map_next;
			retire <= commit;
			if (halt_seen) begin
				halted <= 1'b1;
			end
		end
	end

	// Rename at dispatch must agree with the committed map
	t_old_match: assert property (@(posedge clock) disable iff (rst) !t_old_err)
		else $error("arch_map: committed t_old differs from map entry");

endmodule

// ==== verilog/phys_reg_pkg.sv ====
package phys_reg_pkg;

	// Physical register file size
	parameter int num_phys_reg = 64;

	// Tag width follows from the register count
	parameter int phys_tag_w = $clog2(num_phys_reg);

	// Architectural register file size
	parameter int num_arch_reg = 32;

	// Physical register tag
	typedef logic [phys_tag_w-1:0] phys_tag_t;

	// Architectural register index
	typedef logic [$clog2(num_arch_reg)-1:0] arch_idx_t;

endpackage

// ==== verilog/rob.sv ====
module rob import phys_reg_pkg::*, rob_pkg::*; #(
	parameter int rob_size = 8,
	parameter int ss_size = 2
) (
	input logic clock,
	input logic rst,
	input logic flush,
	input dispatch_pkt_t [ss_size-1:0] dispatch,
	input cdb_pkt_t [ss_size-1:0] cdb,
	output logic [$clog2(rob_size):0] free_rows,
	output retire_pkt_t [ss_size-1:0] commit
);

	localparam int ptr_w = $clog2(rob_size);
	localparam int cnt_w = ptr_w + 1;

	rob_row_t [rob_size-1:0] rows;
	rob_row_t [rob_size-1:0] rows_next;
	logic [ptr_w-1:0] head;
	logic [ptr_w-1:0] tail;
	logic [ptr_w-1:0] head_next;
	logic [ptr_w-1:0] tail_next;
	logic [cnt_w-1:0] free_rows_next;
	logic [cnt_w-1:0] n_ret;
	logic [cnt_w-1:0] n_disp;
	logic [rob_size-1:0] ret_mask;
	logic [ss_size-1:0] disp_valid;
	phys_tag_t [rob_size-1:0] row_tags;
	logic [rob_size-1:0] row_wait;
	logic [rob_size-1:0] hits;

	always_comb begin
		for (int r = 0; r < rob_size; r++) begin
			row_tags[r] = rows[r].t_new;
			row_wait[r] = rows[r].busy & ~rows[r].done;
		end
		for (int i = 0; i < ss_size; i++) begin
			disp_valid[i] = dispatch[i].valid;
		end
	end

	tag_cam #(
		.rob_size(rob_size),
		.ss_size(ss_size)
	) tag_cam_i (
		.row_tags(row_tags),
		.row_wait(row_wait),
		.cdb(cdb),
		.hits(hits)
	);

	// Oldest run of done rows, cut after a halt
	always_comb begin
		logic [ptr_w-1:0] idx;
		logic go;
		commit = '0;
		ret_mask = '0;
		n_ret = '0;
		go = ~flush;
		for (int i = 0; i < ss_size; i++) begin
			idx = head + ptr_w'(i);
			if (go && rows[idx].busy && rows[idx].done) begin
				commit[i].valid = 1'b1;
				commit[i].has_dst = rows[idx].has_dst;
				commit[i].arch_dst = rows[idx].arch_dst;
				commit[i].t_new = rows[idx].t_new;
				commit[i].t_old = rows[idx].t_old;
				commit[i].halt = rows[idx].halt;
				commit[i].npc = rows[idx].npc;
				ret_mask[idx] = 1'b1;
				n_ret = n_ret + 1'b1;
				go = ~rows[idx].halt;
			end else begin
				go = 1'b0;
			end
		end
	end

	always_comb begin
		logic [ptr_w-1:0] idx;
		rows_next = rows;
		n_disp = '0;
		for (int r = 0; r < rob_size; r++) begin
			if (hits[r]) begin
				rows_next[r].done = 1'b1;
			end
			if (ret_mask[r]) begin
				rows_next[r].busy = 1'b0;
				rows_next[r].done = 1'b0;
			end
		end
		// Lanes are packed, so lane i lands at tail + i
		for (int i = 0; i < ss_size; i++) begin
			idx = tail + ptr_w'(i);
			if (disp_valid[i]) begin
				rows_next[idx].busy = 1'b1;
				rows_next[idx].done = ~dispatch[i].has_dst;
				rows_next[idx].has_dst = dispatch[i].has_dst;
				rows_next[idx].arch_dst = dispatch[i].arch_dst;
				rows_next[idx].t_new = dispatch[i].t_new;
				rows_next[idx].t_old = dispatch[i].t_old;
				rows_next[idx].halt = dispatch[i].halt;
				rows_next[idx].npc = dispatch[i].npc;
				n_disp = n_disp + 1'b1;
			end
		end
		head_next = head + n_ret[ptr_w-1:0];
		tail_next = tail + n_disp[ptr_w-1:0];
		free_rows_next = free_rows + n_ret - n_disp;
	end

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			for (int r = 0; r < rob_size; r++) begin
				rows[r].busy <= 1'b0;
				rows[r].done <= 1'b0;
			end
			head <= '0;
			tail <= '0;
			free_rows <= cnt_w'(rob_size);
		end else begin
			rows <= rows_next;
			head <= head_next;
			tail <= tail_next;
			free_rows <= free_rows_next;
		end
	end

	// Producer must respect the free row count
	disp_fits: assert property (@(posedge clock) disable iff (rst)
		n_disp <= free_rows)
		else $error("rob: dispatched more lanes than free rows");

	// Valid lanes form a run starting at lane 0
	disp_packed: assert property (@(posedge clock) disable iff (rst)
		(disp_valid & (disp_valid + 1'b1)) == '0)
		else $error("rob: dispatch lanes not packed from lane 0");

	head_busy: assert property (@(posedge clock) disable iff (rst)
		(free_rows < cnt_w'(rob_size)) |-> rows[head].busy)
		else $error("rob: head row empty while buffer holds entries");

endmodule

// ==== verilog/rob_pkg.sv ====
package rob_pkg;
	import phys_reg_pkg::*;

	// One dispatched instruction, fields commit needs
	typedef struct packed {
		logic        valid;
		logic        has_dst;
		arch_idx_t   arch_dst;
		phys_tag_t   t_new;
		phys_tag_t   t_old;
		logic        halt;
		logic [31:0] npc;
	} dispatch_pkt_t;

	// Result tag broadcast
	typedef struct packed {
		logic      valid;
		phys_tag_t tag;
	} cdb_pkt_t;

	// Reorder buffer row
	typedef struct packed {
		logic        busy;
		logic        done;
		logic        has_dst;
		arch_idx_t   arch_dst;
		phys_tag_t   t_new;
		phys_tag_t   t_old;
		logic        halt;
		logic [31:0] npc;
	} rob_row_t;

	// Retired instruction, same layout as dispatch
	typedef struct packed {
		logic        valid;
		logic        has_dst;
		arch_idx_t   arch_dst;
		phys_tag_t   t_new;
		phys_tag_t   t_old;
		logic        halt;
		logic [31:0] npc;
	} retire_pkt_t;

endpackage

// ==== verilog/rob_subsystem.sv ====
module rob_subsystem import phys_reg_pkg::*, rob_pkg::*; #(
	parameter int rob_size = 8,
	parameter int ss_size = 2
) (
	input logic clock,
	input logic rst,
	input logic flush,
	input dispatch_pkt_t [ss_size-1:0] dispatch,
	input cdb_pkt_t [ss_size-1:0] cdb,
	input arch_idx_t arch_rd_idx,
	output logic [$clog2(rob_size):0] free_rows,
	output retire_pkt_t [ss_size-1:0] retire,
	output phys_tag_t arch_rd_tag,
	output logic halted
);

	// Oldest done entries, combinational from the buffer
	retire_pkt_t [ss_size-1:0] commit;

	rob #(
		.rob_size(rob_size),
		.ss_size(ss_size)
	) rob_i (
		.clock(clock),
		.rst(rst),
		.flush(flush),
		.dispatch(dispatch),
		.cdb(cdb),
		.free_rows(free_rows),
		.commit(commit)
	);

	arch_map #(
		.ss_size(ss_size)
	) arch_map_i (
		.clock(clock),
		.rst(rst),
		.commit(commit),
		.arch_rd_idx(arch_rd_idx),
		.arch_rd_tag(arch_rd_tag),
		.retire(retire),
		.halted(halted)
	);

endmodule

// ==== verilog/tag_cam.sv ====
module tag_cam import phys_reg_pkg::*, rob_pkg::*; #(
	parameter int rob_size = 8,
	parameter int ss_size = 2
) (
	input phys_tag_t [rob_size-1:0] row_tags,
	input logic [rob_size-1:0] row_wait,
	input cdb_pkt_t [ss_size-1:0] cdb,
	output logic [rob_size-1:0] hits
);

	logic dup_tag;

	// Every bus lane against every waiting row, in parallel
	always_comb begin
		hits = '0;
		for (int r = 0; r < rob_size; r++) begin
			for (int l = 0; l < ss_size; l++) begin
				if (row_wait[r] && cdb[l].valid && (cdb[l].tag == row_tags[r])) begin
					hits[r] = 1'b1;
				end
			end
		end
	end

	// Pairwise check of valid bus lanes
	always_comb begin
		dup_tag = 1'b0;
		for (int l = 0; l < ss_size; l++) begin
			for (int m = l + 1; m < ss_size; m++) begin
				if (cdb[l].valid && cdb[m].valid && (cdb[l].tag == cdb[m].tag)) begin
					dup_tag = 1'b1;
				end
			end
		end
	end

	// A physical tag completes once, so two lanes never share it
	cdb_dup_tag: assert final (!dup_tag)
		else $error("tag_cam: two valid data bus lanes carry the same tag");

endmodule
